//--- Makefile
VERILATOR ?= verilator
TOP       := tb_red_reduce
FILELIST  := sim.f
OBJ_DIR   := obj_dir
VFLAGS    := --binary --timing --assert -Wno-fatal -j 0
LINTFLAGS := --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out=$$(./$(OBJ_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST OK"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

//--- red_alu.sv
`timescale 1ns/1ps
`default_nettype none

module red_alu #(
  parameter int unsigned NumRoutes = 4
) (
  input  logic                         clk_i,
  input  logic                         rst_i,
  red_head_if.alu_mp                   head,
  input  logic [$clog2(NumRoutes)-1:0] sel_i,
  input  logic                         fire_i,
  output red_flit_pkg::red_flit_t      out_flit_o
);
  import red_coll_pkg::*;
  import red_flit_pkg::*;

  // All three results are built in parallel
  red_flit_t fwd_flit;
  red_flit_t lsb_and_flit;
  red_flit_t coll_b_flit;
  red_flit_t result;
  red_flit_t out_flit_q;
  logic      lsb;

  // ----------------------------
  // Forward
  // ----------------------------

  // Unicast and select both take the leader
  assign fwd_flit = head.head_flit[sel_i];

  // ----------------------------
  // LSB-AND
  // ----------------------------

  always_comb begin : calc_lsb_and
    lsb = 1'b1;
    for (int i = 0; i < NumRoutes; i++) begin
      if (head.expect_mask[i]) begin
        // Payload read as W data
        lsb &= head.head_flit[i].payload.w_data[0];
      end
    end
    // Leader flit, bit 0 replaced
    lsb_and_flit                    = fwd_flit;
    lsb_and_flit.payload.w_data[0]  = lsb;
  end

  // ----------------------------
  // Collect-B
  // ----------------------------

  // Downward scan, lowest erroring route ends up selected
  // OKAY, EXOKAY and DECERR all fall back to the leader
  always_comb begin : calc_collect_b
    coll_b_flit = fwd_flit;
    for (int i = NumRoutes - 1; i >= 0; i--) begin
      if (head.expect_mask[i] &&
          (head.head_flit[i].payload.b_view.resp == RESP_SLVERR)) begin
        coll_b_flit = head.head_flit[i];
      end
    end
  end

  // ----------------------------
  // Result select and register
  // ----------------------------

  always_comb begin : pick_result
    case (fwd_flit.hdr.op)
      RED_UNICAST,
      RED_SELECT:    result = fwd_flit;
      RED_LSB_AND:   result = lsb_and_flit;
      RED_COLLECT_B: result = coll_b_flit;
      default:       result = fwd_flit;
    endcase
  end

  // Loaded only on fire, holds otherwise
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      out_flit_q <= '0;
    end else if (fire_i) begin
      out_flit_q <= result;
    end
  end

  assign out_flit_o = out_flit_q;

endmodule

`default_nettype wire

//--- red_coll_pkg.sv
`default_nettype none

package red_coll_pkg;

  // ----------------------------
  // Route limits
  // ----------------------------

  // Width of the collective mask
  // and upper bound of NumRoutes
  localparam int unsigned MaxRoutes = 4;

  // ----------------------------
  // Collective operations
  // ----------------------------

  // Operation carried in every flit header
  typedef enum logic [1:0] {
    // Single contributor, forwarded as is
    RED_UNICAST   = 2'd0,
    // Lowest-index contributor wins
    RED_SELECT    = 2'd1,
    // AND over bit 0 of the write data
    RED_LSB_AND   = 2'd2,
    // Merge of B responses, error first
    RED_COLLECT_B = 2'd3
  } red_op_e;

  // Write response codes, AXI encoding
  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_EXOKAY = 2'b01,
    RESP_SLVERR = 2'b10,
    RESP_DECERR = 2'b11
  } red_resp_e;

endpackage

`default_nettype wire

//--- red_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module red_ctrl #(
  parameter int unsigned NumRoutes  = 4,
  parameter int unsigned OutCredits = 2
) (
  input  logic        clk_i,
  input  logic        rst_i,
  red_head_if.ctrl_mp head,
  input  logic        complete_i,
  input  logic        out_credit_i,
  output logic        fire_o,
  output logic        out_valid_o
);

  localparam int unsigned CntW = $clog2(OutCredits + 1);

  logic [CntW-1:0]      credit_q;
  logic                 has_credit;
  logic                 fire;
  logic [NumRoutes-1:0] pop_mask;
  logic                 out_valid_q;

  // ----------------------------
  // Fire decision
  // ----------------------------

  assign has_credit = (credit_q != '0);

  // Fires in the same cycle the last head shows up
  assign fire = complete_i && has_credit;

  // Pop exactly the expected routes
  // routes outside the mask keep their heads
  assign pop_mask = fire ? (head.expect_mask & head.head_valid) : '0;
  assign head.pop = pop_mask;

  // ----------------------------
  // Output credits
  // ----------------------------

  // Starts full, one credit per flit sent downstream
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      credit_q <= CntW'(OutCredits);
    end else begin
      case ({fire, out_credit_i})
        // Consume only
        2'b10:   credit_q <= credit_q - CntW'(1);
        // Return only
        2'b01:   credit_q <= credit_q + CntW'(1);
        // Both or neither, level unchanged
        default: credit_q <= credit_q;
      endcase
    end
  end

  // Output valid lags fire by one cycle,
  // lined up with the ALU output register
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      out_valid_q <= 1'b0;
    end else begin
      out_valid_q <= fire;
    end
  end

  assign fire_o      = fire;
  assign out_valid_o = out_valid_q;

endmodule

`default_nettype wire

//--- red_flit_pkg.sv
`default_nettype none

package red_flit_pkg;

  // ----------------------------
  // Header
  // ----------------------------

  // 12-bit header, op in the top bits
  typedef struct packed {
    red_coll_pkg::red_op_e              op;
    // One bit per contributing route
    logic [red_coll_pkg::MaxRoutes-1:0] coll_mask;
    logic [5:0]                         src_id;
  } red_hdr_t;

  // ----------------------------
  // Payload
  // ----------------------------

  // Payload seen as a B response
  typedef struct packed {
    red_coll_pkg::red_resp_e resp;
    logic [5:0]              bid;
    logic [23:0]             unused;
  } red_b_view_t;

  // Same 32 bits, decoded by op
  // W data for select and LSB-AND, B view for collect-B
  typedef union packed {
    logic [31:0] w_data;
    red_b_view_t b_view;
  } red_payload_u;

  // Full 44-bit flit
  typedef struct packed {
    red_hdr_t     hdr;
    red_payload_u payload;
  } red_flit_t;

endpackage

`default_nettype wire

//--- red_head_if.sv
`timescale 1ns/1ps
`default_nettype none

interface red_head_if #(
  parameter int unsigned NumRoutes = 4
);
  import red_flit_pkg::*;

  // Head of each route buffer
  logic      [NumRoutes-1:0] head_valid;
  red_flit_t [NumRoutes-1:0] head_flit;
  // Pop strobe back to the buffers
  logic      [NumRoutes-1:0] pop;
  // Routes taking part in the current reduction
  logic      [NumRoutes-1:0] expect_mask;

  // Buffers own the heads
  modport buf_mp (
    output head_valid,
    output head_flit,
    input  pop
  );

  // Sync decides which routes are expected
  modport sync_mp (
    input  head_valid,
    input  head_flit,
    output expect_mask
  );

  // Control pops the expected routes
  modport ctrl_mp (
    input  head_valid,
    input  expect_mask,
    output pop
  );

  // ALU reads the contributors
  modport alu_mp (
    input  head_flit,
    input  expect_mask
  );

endinterface

`default_nettype wire

//--- red_in_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module red_in_buffer #(
  parameter int unsigned BufDepth = 4
) (
  input  logic                    clk_i,
  input  logic                    rst_i,
  // Upstream side
  input  logic                    valid_i,
  input  red_flit_pkg::red_flit_t flit_i,
  output logic                    credit_o,
  // Head toward sync, control and ALU
  output logic                    head_valid_o,
  output red_flit_pkg::red_flit_t head_flit_o,
  input  logic                    pop_i
);
  import red_flit_pkg::*;

  localparam int unsigned PtrW = (BufDepth > 1) ? $clog2(BufDepth) : 1;
  localparam int unsigned CntW = $clog2(BufDepth + 1);

  // Flit storage
  red_flit_t       mem_q [BufDepth];
  logic [PtrW-1:0] wr_ptr_q;
  logic [PtrW-1:0] rd_ptr_q;
  logic [CntW-1:0] count_q;
  logic            push;
  logic            pop;
  logic            credit_q;

  // Advance a pointer with wrap at BufDepth
  function automatic logic [PtrW-1:0] ptr_next(input logic [PtrW-1:0] ptr);
    if (ptr == PtrW'(BufDepth - 1)) begin
      return '0;
    end
    return ptr + PtrW'(1);
  endfunction

  // Sender only pushes with a credit
  // a push into a full buffer is dropped
  assign push = valid_i && (count_q != CntW'(BufDepth));
  assign pop  = pop_i && head_valid_o;

  // ----------------------------
  // Write side
  // ----------------------------

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= flit_i;
    end
  end

  // Pointers, fill level and credit return
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
      credit_q <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr_q <= ptr_next(wr_ptr_q);
      end
      if (pop) begin
        rd_ptr_q <= ptr_next(rd_ptr_q);
      end
      // Simultaneous push and pop keeps the level
      case ({push, pop})
        2'b10:   count_q <= count_q + CntW'(1);
        2'b01:   count_q <= count_q - CntW'(1);
        default: count_q <= count_q;
      endcase
      // One credit pulse per freed slot
      credit_q <= pop;
    end
  end

  // ----------------------------
  // Read side
  // ----------------------------

  // Head is combinational off the read pointer
  assign head_valid_o = (count_q != '0);
  assign head_flit_o  = mem_q[rd_ptr_q];
  assign credit_o     = credit_q;

endmodule

`default_nettype wire

//--- red_reduce_top.sv
`timescale 1ns/1ps
`default_nettype none

module red_reduce_top #(
  parameter int unsigned NumRoutes  = 4,
  parameter int unsigned BufDepth   = 4,
  parameter int unsigned OutCredits = 2
) (
  input  logic                                    clk_i,
  input  logic                                    rst_i,
  // Input routes
  input  logic                    [NumRoutes-1:0] in_valid_i,
  input  red_flit_pkg::red_flit_t [NumRoutes-1:0] in_flit_i,
  output logic                    [NumRoutes-1:0] in_credit_o,
  // Output port
  output logic                                    out_valid_o,
  output red_flit_pkg::red_flit_t                 out_flit_o,
  input  logic                                    out_credit_i
);

  localparam int unsigned SelW = $clog2(NumRoutes);

  logic            complete;
  logic            fire;
  logic [SelW-1:0] sel;

  // Buffer heads shared by sync, control and ALU
  red_head_if #(.NumRoutes(NumRoutes)) heads ();

  // ----------------------------
  // Route buffers
  // ----------------------------

  for (genvar g = 0; g < NumRoutes; g++) begin : gen_route
    // One lane of the head bundle each
    red_in_buffer #(
      .BufDepth (BufDepth)
    ) i_in_buffer (
      .clk_i        (clk_i),
      .rst_i        (rst_i),
      .valid_i      (in_valid_i[g]),
      .flit_i       (in_flit_i[g]),
      .credit_o     (in_credit_o[g]),
      .head_valid_o (heads.head_valid[g]),
      .head_flit_o  (heads.head_flit[g]),
      .pop_i        (heads.pop[g])
    );
  end

  // ----------------------------
  // Reduction core
  // ----------------------------

  red_sync #(
    .NumRoutes (NumRoutes)
  ) i_sync (
    .head       (heads.sync_mp),
    .complete_o (complete),
    .sel_o      (sel)
  );

  red_ctrl #(
    .NumRoutes  (NumRoutes),
    .OutCredits (OutCredits)
  ) i_ctrl (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .head         (heads.ctrl_mp),
    .complete_i   (complete),
    .out_credit_i (out_credit_i),
    .fire_o       (fire),
    .out_valid_o  (out_valid_o)
  );

  red_alu #(
    .NumRoutes (NumRoutes)
  ) i_alu (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .head       (heads.alu_mp),
    .sel_i      (sel),
    .fire_i     (fire),
    .out_flit_o (out_flit_o)
  );

endmodule

`default_nettype wire

//--- red_sync.sv
`timescale 1ns/1ps
`default_nettype none

module red_sync #(
  parameter int unsigned NumRoutes = 4
) (
  red_head_if.sync_mp                  head,
  output logic                         complete_o,
  output logic [$clog2(NumRoutes)-1:0] sel_o
);
  import red_coll_pkg::*;
  import red_flit_pkg::*;

  localparam int unsigned SelW = $clog2(NumRoutes);

  logic [SelW-1:0]      sel;
  logic                 any_valid;
  red_flit_t            sel_flit;
  logic [NumRoutes-1:0] sel_onehot;
  logic [NumRoutes-1:0] mask;
  logic [NumRoutes-1:0] arrived;

  // ----------------------------
  // Leading route
  // ----------------------------

  // Zero-count search from index 0
  // scanning down so the lowest valid index is kept
  always_comb begin : find_leader
    sel       = '0;
    any_valid = 1'b0;
    for (int i = NumRoutes - 1; i >= 0; i--) begin
      if (head.head_valid[i]) begin
        sel       = SelW'(i);
        any_valid = 1'b1;
      end
    end
  end

  assign sel_flit   = head.head_flit[sel];
  assign sel_onehot = NumRoutes'(1) << sel;

  // ----------------------------
  // Expected contributors
  // ----------------------------

  always_comb begin : build_mask
    if (!any_valid) begin
      mask = '0;
    end else if ((sel_flit.hdr.op == RED_UNICAST) ||
                 (sel_flit.hdr.coll_mask[NumRoutes-1:0] == '0)) begin
      // Only the leader itself
      mask = sel_onehot;
    end else begin
      // Mask limited to the built routes, leader always included
      mask = sel_flit.hdr.coll_mask[NumRoutes-1:0] | sel_onehot;
    end
  end

  // A route counts only when its head belongs to the same op
  // otherwise it is waited on
  always_comb begin : match_heads
    for (int i = 0; i < NumRoutes; i++) begin
      arrived[i] = head.head_valid[i] && (head.head_flit[i].hdr.op == sel_flit.hdr.op);
    end
  end

  assign head.expect_mask = mask;
  assign complete_o       = any_valid && ((mask & ~arrived) == '0);
  assign sel_o            = sel;

endmodule

`default_nettype wire

//--- red_testdata.hex
// kind_cycle_route_flit, kind 00 stimulus, 01 expected output, 02 downstream credit hold
// cycle in hex after reset, for 01 the route digit is the test number, for 02 flit is the length
// Unicast on several routes
00_01_0_001DEADBEEF
01_00_0_001DEADBEEF
00_04_2_0020BADF00D
01_00_0_0020BADF00D
00_07_3_00300000001
01_00_0_00300000001
// Select over two routes, then over all four in reverse order
00_0A_1_58A11111111
00_0D_2_58B22222222
01_00_1_58A11111111
00_10_3_7D3A3A3A3A3
00_11_2_7D2A2A2A2A2
00_12_1_7D1A1A1A1A1
00_14_0_7D0A0A0A0A0
01_00_1_7D0A0A0A0A0
// LSB-AND, all ones then a single zero on route 3
00_18_0_9C100000011
00_19_1_9C200000101
00_1A_2_9C3FFFFFFFF
01_00_2_9C100000011
00_1E_3_A45FFFFFFFE
00_1F_0_A4412345679
01_00_2_A4412345678
// Collect-B, lowest SLVERR wins, then DECERR OKAY EXOKAY mix
00_23_1_F8105000000
00_23_2_F8286000000
00_24_3_F8387000000
01_00_3_F8286000000
00_28_0_DC4C1000000
00_28_1_DC502000000
00_28_2_DC643000000
01_00_3_DC4C1000000
// Back-pressure, downstream credits held for 30 cycles
02_32_0_0000000001E
00_33_0_02000000010
00_33_1_02100000020
00_34_0_02000000011
00_34_1_02100000021
00_35_0_02000000012
00_36_0_02000000013
01_00_4_02000000010
01_00_4_02000000011
01_00_4_02000000012
01_00_4_02000000013
01_00_4_02100000020
01_00_4_02100000021
// Other op and other routes wait for their own turn
00_6E_1_4C951515151
00_6E_2_00E52525252
00_6E_3_00F53535353
00_71_0_00D50505050
00_74_0_4C850000001
01_00_5_00D50505050
01_00_5_4C850000001
01_00_5_00E52525252
01_00_5_00F53535353

//--- sim.f
red_coll_pkg.sv
red_flit_pkg.sv
red_head_if.sv
red_in_buffer.sv
red_sync.sv
red_alu.sv
red_ctrl.sv
red_reduce_top.sv
tb_red_reduce.sv

//--- tb_red_reduce.sv
`timescale 1ns/1ps
`default_nettype none

module tb_red_reduce;
  import red_flit_pkg::*;

  localparam int NumRoutes  = 4;
  localparam int BufDepth   = 4;
  localparam int OutCredits = 2;
  localparam int RecMax     = 128;
  localparam int NumTests   = 6;

  // Record kinds in the data file
  localparam logic [7:0] KindStim = 8'h00;
  localparam logic [7:0] KindExp  = 8'h01;
  localparam logic [7:0] KindHold = 8'h02;
  localparam logic [7:0] KindEnd  = 8'hff;

  logic                      clk_i;
  logic                      rst_i;
  logic      [NumRoutes-1:0] in_valid_i;
  red_flit_t [NumRoutes-1:0] in_flit_i;
  logic      [NumRoutes-1:0] in_credit_o;
  logic                      out_valid_o;
  red_flit_t                 out_flit_o;
  logic                      out_credit_i;

  logic [63:0] recs [RecMax];
  // Pending stimulus, as record indices in file order
  int          stim_q[$];
  logic [43:0] exp_q[$];
  int          exp_id_q[$];
  // Cycle at which each downstream credit goes back
  int          ret_q[$];
  int          up_credit [NumRoutes];
  int          sent_cnt [NumRoutes];
  int          credit_cnt [NumRoutes];
  string       test_names [NumTests] = '{"unicast", "select", "lsb_and",
                                         "collect_b", "back_pressure", "mask_skip"};
  logic [31:0] lfsr_q;
  int          cycle;
  int          limit;
  int          num_recs;
  int          hold_start;
  int          hold_len;
  int          outstanding;
  int          value_errors;
  int          credit_errors;
  int          proto_errors;

  red_reduce_top #(
    .NumRoutes  (NumRoutes),
    .BufDepth   (BufDepth),
    .OutCredits (OutCredits)
  ) i_red_reduce_top (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .in_valid_i   (in_valid_i),
    .in_flit_i    (in_flit_i),
    .in_credit_o  (in_credit_o),
    .out_valid_o  (out_valid_o),
    .out_flit_o   (out_flit_o),
    .out_credit_i (out_credit_i)
  );

  // 40 ns clock
  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  // ----------------------------
  // Helpers
  // ----------------------------

  // Fibonacci LFSR, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // One LFSR step per bit taken
  task automatic draw_bits(input int n, output int val);
    val = 0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      val    = (val << 1) | int'(lfsr_q[0]);
    end
  endtask

  function automatic string name_of(input int id);
    if (id >= 0 && id < NumTests) begin
      return test_names[id];
    end
    return "unknown";
  endfunction

  // Sort the records into stimulus, expected flits and the hold window
  task automatic load_records();
    logic [7:0] kind;
    int         route;
    logic       done;
    for (int i = 0; i < RecMax; i++) begin
      recs[i] = {KindEnd, 56'h0};
    end
    $readmemh("red_testdata.hex", recs);
    num_recs = 0;
    done     = 1'b0;
    for (int i = 0; i < RecMax; i++) begin
      kind  = recs[i][63:56];
      route = int'(recs[i][47:44]);
      if (kind == KindEnd) begin
        done = 1'b1;
      end
      if (!done) begin
        num_recs++;
        if (kind == KindStim && route < NumRoutes) begin
          stim_q.push_back(i);
        end else if (kind == KindExp) begin
          exp_q.push_back(recs[i][43:0]);
          exp_id_q.push_back(route);
        end else if (kind == KindHold) begin
          hold_start = int'(recs[i][55:48]);
          hold_len   = int'(recs[i][31:0]);
        end else begin
          $display("Record %0d is malformed: kind %h route %0d", i, kind, route);
          proto_errors++;
        end
      end
    end
    assert (num_recs > 0 && exp_q.size() > 0) else begin
      $display("No usable records were read from red_testdata.hex");
      proto_errors++;
    end
  endtask

  // ----------------------------
  // Per-cycle work, at the falling edge
  // ----------------------------

  task automatic check_outputs();
    logic [43:0] exp;
    logic [43:0] got;
    int          id;
    int          delay;
    // Input credits back from the buffers
    for (int r = 0; r < NumRoutes; r++) begin
      if (in_credit_o[r]) begin
        up_credit[r]++;
        credit_cnt[r]++;
      end
    end
    if (out_valid_o) begin
      got = out_flit_o;
      assert (exp_q.size() > 0) else begin
        $display("Output flit %h arrived after all expected flits were seen", got);
        proto_errors++;
      end
      if (exp_q.size() > 0) begin
        exp = exp_q.pop_front();
        id  = exp_id_q.pop_front();
        assert (got == exp) else begin
          $display("[FAIL] %s expected %h actual %h", name_of(id), exp, got);
          value_errors++;
        end
      end
      outstanding++;
      assert (outstanding <= OutCredits) else begin
        $display("More output flits in flight than the %0d downstream credits", OutCredits);
        proto_errors++;
      end
      // Consumer frees the slot 1 to 4 cycles later
      draw_bits(2, delay);
      ret_q.push_back(cycle + 1 + delay);
    end
  endtask

  // Downstream consumer, silent inside the hold window
  task automatic drive_credit_return();
    logic held;
    held         = (cycle >= hold_start) && (cycle < hold_start + hold_len);
    out_credit_i = 1'b0;
    if (!held && ret_q.size() > 0) begin
      if (ret_q[0] <= cycle) begin
        ret_q.delete(0);
        out_credit_i = 1'b1;
        outstanding--;
      end
    end
  endtask

  // Upstream senders, oldest record per route only, never without a credit
  task automatic drive_routes();
    logic [NumRoutes-1:0] seen;
    int                   idx;
    int                   r;
    int                   k;
    in_valid_i = '0;
    seen       = '0;
    k          = 0;
    while (k < stim_q.size()) begin
      idx = stim_q[k];
      r   = int'(recs[idx][47:44]);
      if (!seen[r] && int'(recs[idx][55:48]) <= cycle && up_credit[r] > 0) begin
        seen[r]       = 1'b1;
        in_valid_i[r] = 1'b1;
        in_flit_i[r]  = recs[idx][43:0];
        up_credit[r]--;
        sent_cnt[r]++;
        stim_q.delete(k);
      end else begin
        seen[r] = 1'b1;
        k++;
      end
    end
  endtask

  // One input credit per flit sent
  task automatic check_credit_totals();
    for (int r = 0; r < NumRoutes; r++) begin
      assert (credit_cnt[r] == sent_cnt[r]) else begin
        $display("Route %0d returned %0d input credits for %0d flits sent",
                 r, credit_cnt[r], sent_cnt[r]);
        credit_errors++;
      end
    end
  endtask

  // ----------------------------
  // Main sequence
  // ----------------------------

  initial begin : main
    int drain;
    rst_i         = 1'b1;
    in_valid_i    = '0;
    in_flit_i     = '0;
    out_credit_i  = 1'b0;
    value_errors  = 0;
    credit_errors = 0;
    proto_errors  = 0;
    outstanding   = 0;
    hold_start    = 0;
    hold_len      = 0;
    lfsr_q        = 32'hf7f0_9099;
    for (int r = 0; r < NumRoutes; r++) begin
      up_credit[r]  = BufDepth;
      sent_cnt[r]   = 0;
      credit_cnt[r] = 0;
    end
    load_records();
    limit = 20 * num_recs + 200;

    // Two cycles of reset
    repeat (2) @(posedge clk_i);
    @(negedge clk_i);
    rst_i = 1'b0;

    cycle = 0;
    drain = 0;
    // Runs on a few cycles past the last output so credit pulses land
    while (drain < 10 && cycle < limit) begin
      @(negedge clk_i);
      check_outputs();
      drive_credit_return();
      drive_routes();
      if (stim_q.size() == 0 && exp_q.size() == 0) begin
        drain++;
      end else begin
        drain = 0;
      end
      cycle++;
    end

    if (drain < 10) begin
      $display("Timeout after %0d cycles: %0d flits unsent, %0d outputs never seen",
               cycle, stim_q.size(), exp_q.size());
      proto_errors++;
    end
    check_credit_totals();

    $display("Errors: %0d value, %0d credit, %0d protocol",
             value_errors, credit_errors, proto_errors);
    if (value_errors + credit_errors + proto_errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
